// File: common/dac_array_pkg.sv
// DAC array package with code widths, resolution select and capacitor array types
package dac_array_pkg;

    // ========================================
    // Array geometry
    // ========================================

    localparam int DAC_WIDTH = 16;                  // Full capacitor array width

    // Input codes, output levels and switch vectors
    typedef logic [DAC_WIDTH-1:0] dac_code_t;

    // Resolution selector, 11 decodes as 16 bits
    typedef logic [1:0] res_sel_t;

    localparam res_sel_t RES_12 = 2'b00;            // 12-bit array
    localparam res_sel_t RES_14 = 2'b01;            // 14-bit array

    // Midscale level, top bit only
    localparam dac_code_t MIDSCALE = dac_code_t'(1) << (DAC_WIDTH - 1);

    // ========================================
    // Resolution decode
    // ========================================

    // Number of active array positions for a selector value
    function automatic int res_bits(res_sel_t res);
        case (res)
            RES_12:  return 12;
            RES_14:  return 14;
            default: return DAC_WIDTH;              // 10 and 11 both full width
        endcase
    endfunction

endpackage

// File: common/dac_ctrl_pkg.sv
// DAC control package with handshake states, settle counts and calibration fields
package dac_ctrl_pkg;

    // ========================================
    // Calibration
    // ========================================

    typedef logic [7:0] cal_code_t;                 // Gain nibble high, offset nibble low

    localparam int CAL_FIELD_W  = 4;                // Nibble per trim field
    localparam int CAL_OFS_LSB  = 0;                // Offset field position
    localparam int CAL_GAIN_LSB = 4;                // Gain field position

    localparam logic [CAL_FIELD_W-1:0] CAL_CENTER = 4'd8;   // Zero trim
    localparam int GAIN_SHIFT = 10;                 // One gain step = level / 1024

    // ========================================
    // Handshake and settling
    // ========================================

    typedef logic [3:0] settle_cnt_t;

    // Four-phase handshake FSM
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_SETTLE,
        HS_ACK,
        HS_RELEASE
    } hs_state_t;

    // Default settle cycles, larger array settles slower
    localparam int SETTLE_12_DEF = 4;
    localparam int SETTLE_14_DEF = 6;
    localparam int SETTLE_16_DEF = 8;

endpackage

// File: dac_core/dac_switch_ctrl.sv
// DAC switch control holding capacitor switch positions and forming the charge-sum level
`timescale 1ns/1ps

module dac_switch_ctrl (
    input  logic                      clk_i,
    input  logic                      reset_n_i,
    input  logic                      load_i,        // Capture pulse from the timer
    input  logic                      reset_dac_i,   // All used positions to mid
    input  dac_array_pkg::res_sel_t   resolution_i,
    input  dac_array_pkg::dac_code_t  dac_code_i,
    output dac_array_pkg::dac_code_t  dac_level_o    // Left-aligned level
);

    // ========================================
    // Switch decode
    // ========================================

    dac_array_pkg::dac_code_t  sw_high_d;   // Next high positions
    dac_array_pkg::dac_code_t  sw_mid_d;    // Next mid positions
    dac_array_pkg::dac_code_t  sw_high_q;   // Held high positions
    dac_array_pkg::dac_code_t  sw_mid_q;    // Held mid positions
    dac_array_pkg::res_sel_t   res_q;       // Resolution of the held code
    dac_array_pkg::dac_code_t  charge_sum;  // Sum of high binary weights
    int                        used_bits;   // Active positions for the new code
    int                        align_shift; // Shift to the top of the array

    always_comb begin
        used_bits = dac_array_pkg::res_bits(resolution_i);
        for (int i = 0; i < dac_array_pkg::DAC_WIDTH; i++) begin
            if (i < used_bits) begin
                // Code bit picks high or low, reset forces mid
                sw_high_d[i] = dac_code_i[i] & ~reset_dac_i;
                sw_mid_d[i]  = reset_dac_i;
            end else begin
                sw_high_d[i] = 1'b0;                // Unused caps parked at mid
                sw_mid_d[i]  = 1'b1;
            end
        end
    end

    // Low position is implied by neither high nor mid
    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            sw_high_q <= '0;
            sw_mid_q  <= '0;
            res_q     <= '0;
        end else if (load_i) begin
            sw_high_q <= sw_high_d;
            sw_mid_q  <= sw_mid_d;
            res_q     <= resolution_i;
        end
    end

    // ========================================
    // Charge summation
    // ========================================

    always_comb begin
        charge_sum = '0;
        for (int i = 0; i < dac_array_pkg::DAC_WIDTH; i++) begin
            if (sw_high_q[i]) begin
                charge_sum = charge_sum + (dac_array_pkg::dac_code_t'(1) << i);  // Weight 2^i
            end
        end

        // 12 and 14 bit codes sit at the top of the 16-bit level
        align_shift = dac_array_pkg::DAC_WIDTH - dac_array_pkg::res_bits(res_q);

        // Unused positions are always mid, so all-ones means full midscale reset
        if (&sw_mid_q) begin
            dac_level_o = dac_array_pkg::MIDSCALE;
        end else begin
            dac_level_o = charge_sum << align_shift;
        end
    end

endmodule

// File: dac_core/dac_cal_trim.sv
// DAC calibration trim applying offset and gain from the cal register with saturation
`timescale 1ns/1ps

module dac_cal_trim (
    input  logic                      clk_i,
    input  logic                      reset_n_i,
    input  logic                      cal_valid_i,   // Load strobe for the cal code
    input  logic                      cal_enable_i,  // Apply trim
    input  dac_ctrl_pkg::cal_code_t   cal_code_i,
    input  dac_array_pkg::dac_code_t  dac_level_i,
    output dac_array_pkg::dac_code_t  dac_out_p_o,
    output dac_array_pkg::dac_code_t  dac_out_n_o    // Complement of p
);

    dac_ctrl_pkg::cal_code_t  cal_q;      // Held calibration code
    logic signed [23:0]       level_s;    // Level, sign extended
    logic signed [23:0]       gain_d;     // Gain nibble minus center
    logic signed [23:0]       ofs_d;      // Offset nibble minus center
    logic signed [23:0]       gain_prod;  // Level times gain step
    logic signed [23:0]       trim_acc;   // Trimmed level before clamp

    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            cal_q <= '0;
        end else if (cal_valid_i) begin
            cal_q <= cal_code_i;
        end
    end

    // ========================================
    // Trim arithmetic
    // ========================================

    always_comb begin
        level_s = $signed({8'd0, dac_level_i});
        gain_d  = $signed({20'd0, cal_q[dac_ctrl_pkg::CAL_GAIN_LSB +: dac_ctrl_pkg::CAL_FIELD_W]})
                - $signed({20'd0, dac_ctrl_pkg::CAL_CENTER});
        ofs_d   = $signed({20'd0, cal_q[dac_ctrl_pkg::CAL_OFS_LSB +: dac_ctrl_pkg::CAL_FIELD_W]})
                - $signed({20'd0, dac_ctrl_pkg::CAL_CENTER});

        gain_prod = level_s * gain_d;                                    // At most 2^19 in size
        trim_acc  = level_s + (gain_prod >>> dac_ctrl_pkg::GAIN_SHIFT) + ofs_d;

        if (!cal_enable_i) begin
            dac_out_p_o = dac_level_i;                  // Bypass
        end else if (trim_acc[23]) begin
            dac_out_p_o = '0;                           // Clamp low
        end else if (trim_acc > 24'sd65535) begin
            dac_out_p_o = '1;                           // Clamp at full scale
        end else begin
            dac_out_p_o = trim_acc[15:0];
        end
    end

    // Full scale minus p on the negative side
    assign dac_out_n_o = ~dac_out_p_o;

endmodule

// File: src/dac_settle_timer.sv
// DAC settle timer running the four-phase handshake and resolution-dependent settling
`timescale 1ns/1ps

module dac_settle_timer #(
    parameter int SETTLE_12 = dac_ctrl_pkg::SETTLE_12_DEF,
    parameter int SETTLE_14 = dac_ctrl_pkg::SETTLE_14_DEF,
    parameter int SETTLE_16 = dac_ctrl_pkg::SETTLE_16_DEF
) (
    input  logic                     clk_i,
    input  logic                     reset_n_i,
    input  logic                     enable_i,
    input  logic                     req_i,
    input  dac_array_pkg::res_sel_t  resolution_i,
    output logic                     load_o,      // Capture pulse to the switch array
    output logic                     ack_o,
    output logic                     ready_o,
    output logic                     busy_o       // High while settling
);

    // Settle counts stand in for the RC time of the larger array
    localparam dac_ctrl_pkg::settle_cnt_t CNT_12 = dac_ctrl_pkg::settle_cnt_t'(SETTLE_12);
    localparam dac_ctrl_pkg::settle_cnt_t CNT_14 = dac_ctrl_pkg::settle_cnt_t'(SETTLE_14);
    localparam dac_ctrl_pkg::settle_cnt_t CNT_16 = dac_ctrl_pkg::settle_cnt_t'(SETTLE_16);

    dac_ctrl_pkg::hs_state_t    state_q;
    dac_ctrl_pkg::settle_cnt_t  cnt_q;      // Remaining settle cycles
    dac_ctrl_pkg::settle_cnt_t  cnt_init;   // Count for the current resolution
    logic                       accept;     // Request taken this edge

    always_comb begin
        case (resolution_i)
            dac_array_pkg::RES_12: cnt_init = CNT_12;
            dac_array_pkg::RES_14: cnt_init = CNT_14;
            default:               cnt_init = CNT_16;
        endcase
    end

    assign accept = req_i && !ack_o && enable_i && (state_q == dac_ctrl_pkg::HS_IDLE);

    // ========================================
    // Handshake FSM
    // ========================================

    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            state_q <= dac_ctrl_pkg::HS_IDLE;
            cnt_q   <= '0;
            load_o  <= 1'b0;
        end else begin
            load_o <= accept;                       // One cycle, req is gone from idle next
            case (state_q)
                dac_ctrl_pkg::HS_IDLE: begin
                    if (accept) begin
                        state_q <= dac_ctrl_pkg::HS_SETTLE;
                        cnt_q   <= cnt_init;
                    end
                end
                dac_ctrl_pkg::HS_SETTLE: begin
                    // Ack lands S+1 edges after acceptance
                    if (cnt_q == '0) begin
                        state_q <= dac_ctrl_pkg::HS_ACK;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                dac_ctrl_pkg::HS_ACK: begin
                    if (!req_i) begin
                        state_q <= dac_ctrl_pkg::HS_RELEASE;  // Slow release just waits here
                    end
                end
                dac_ctrl_pkg::HS_RELEASE: state_q <= dac_ctrl_pkg::HS_IDLE;
                default:                  state_q <= dac_ctrl_pkg::HS_IDLE;
            endcase
        end
    end

    // Status decoded straight from state
    assign ack_o   = (state_q == dac_ctrl_pkg::HS_ACK);
    assign busy_o  = (state_q == dac_ctrl_pkg::HS_SETTLE);
    assign ready_o = (state_q == dac_ctrl_pkg::HS_IDLE) && enable_i;

endmodule

// File: src/sar_dac_top.sv
// SAR DAC controller top level joining the handshake timer, switch array and trim
`timescale 1ns/1ps

module sar_dac_top #(
    parameter int SETTLE_12 = dac_ctrl_pkg::SETTLE_12_DEF,  // Settle cycles at 12 bits
    parameter int SETTLE_14 = dac_ctrl_pkg::SETTLE_14_DEF,  // Settle cycles at 14 bits
    parameter int SETTLE_16 = dac_ctrl_pkg::SETTLE_16_DEF   // Settle cycles at 16 bits
) (
    input  logic                      clk_i,
    input  logic                      reset_n_i,
    input  logic                      enable_i,      // Gates request acceptance
    input  logic                      req_i,         // Four-phase request
    input  logic                      reset_dac_i,   // Midscale reset with the load
    input  logic                      cal_valid_i,   // Load cal_code_i
    input  logic                      cal_enable_i,  // Trim on
    input  dac_array_pkg::res_sel_t   resolution_i,
    input  dac_array_pkg::dac_code_t  dac_code_i,
    input  dac_ctrl_pkg::cal_code_t   cal_code_i,
    output logic                      ack_o,
    output logic                      ready_o,
    output logic                      busy_o,
    output dac_array_pkg::dac_code_t  dac_out_p_o,
    output dac_array_pkg::dac_code_t  dac_out_n_o
);

    logic                      load;       // One-cycle capture pulse
    dac_array_pkg::dac_code_t  dac_level;  // Untrimmed charge-sum level

    // Handshake and settling
    dac_settle_timer #(
        .SETTLE_12 (SETTLE_12),
        .SETTLE_14 (SETTLE_14),
        .SETTLE_16 (SETTLE_16)
    ) u_settle_timer (
        .clk_i        (clk_i),
        .reset_n_i    (reset_n_i),
        .enable_i     (enable_i),
        .req_i        (req_i),
        .resolution_i (resolution_i),
        .load_o       (load),
        .ack_o        (ack_o),
        .ready_o      (ready_o),
        .busy_o       (busy_o)
    );

    // Capacitor switches and charge sum
    dac_switch_ctrl u_switch_ctrl (
        .clk_i        (clk_i),
        .reset_n_i    (reset_n_i),
        .load_i       (load),
        .reset_dac_i  (reset_dac_i),
        .resolution_i (resolution_i),
        .dac_code_i   (dac_code_i),
        .dac_level_o  (dac_level)
    );

    // Offset and gain trim, differential outputs
    dac_cal_trim u_cal_trim (
        .clk_i        (clk_i),
        .reset_n_i    (reset_n_i),
        .cal_valid_i  (cal_valid_i),
        .cal_enable_i (cal_enable_i),
        .cal_code_i   (cal_code_i),
        .dac_level_i  (dac_level),
        .dac_out_p_o  (dac_out_p_o),
        .dac_out_n_o  (dac_out_n_o)
    );

endmodule

// File: tests/sar_dac_sva.sv
// Handshake and output assertions for the SAR DAC controller, bound to the top level
`timescale 1ns/1ps

module sar_dac_sva (
    input logic                      clk_i,
    input logic                      reset_n_i,
    input logic                      req_i,
    input logic                      ack_o,
    input logic                      busy_o,
    input dac_array_pkg::dac_code_t  dac_out_p_o,
    input dac_array_pkg::dac_code_t  dac_out_n_o
);

    // ========================================
    // Handshake
    // ========================================

    // Ack answers a request that was high when it rose
    ack_needs_req: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        $rose(ack_o) |-> $past(req_i))
        else $error("ack_o rose while req_i was low");

    busy_ack_excl: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        !(busy_o && ack_o))
        else $error("busy_o and ack_o high together");

    // ========================================
    // Outputs
    // ========================================

    n_is_complement: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        dac_out_n_o == ~dac_out_p_o)
        else $error("dac_out_n_o is not the complement of dac_out_p_o");

endmodule

bind sar_dac_top sar_dac_sva u_sva (
    .clk_i       (clk_i),
    .reset_n_i   (reset_n_i),
    .req_i       (req_i),
    .ack_o       (ack_o),
    .busy_o      (busy_o),
    .dac_out_p_o (dac_out_p_o),
    .dac_out_n_o (dac_out_n_o)
);

// File: tests/tb_sar_dac.sv
// Testbench for the SAR DAC controller with LFSR stimulus and a reference model
`timescale 1ns/1ps

module tb_sar_dac;

    localparam int CLK_PERIOD  = 100;
    localparam int SET_12      = 4;                 // Settle cycles per resolution
    localparam int SET_14      = 6;
    localparam int SET_16      = 8;
    localparam int N_RAND      = 16;                // Random codes per selector value
    localparam int N_CAL       = 16;
    localparam int N_TRANS     = 4 * N_RAND + 3 + N_CAL + 2 + 3 + 1;
    localparam int MAX_HS      = 32;                // Longest handshake incl. slow release
    localparam int WATCHDOG_NS = (N_TRANS * MAX_HS + 100) * CLK_PERIOD * 2;

    logic        clk, reset_n, enable, req, reset_dac, cal_valid, cal_enable;
    logic [1:0]  resolution;
    logic [15:0] dac_code;
    logic [7:0]  cal_code;
    logic        ack, ready, busy;
    logic [15:0] dac_out_p, dac_out_n;

    logic [15:0] lfsr_state;
    int          checks, errors, test_errs;

    sar_dac_top #(
        .SETTLE_12 (SET_12),
        .SETTLE_14 (SET_14),
        .SETTLE_16 (SET_16)
    ) dut (
        .clk_i        (clk),
        .reset_n_i    (reset_n),
        .enable_i     (enable),
        .req_i        (req),
        .reset_dac_i  (reset_dac),
        .cal_valid_i  (cal_valid),
        .cal_enable_i (cal_enable),
        .resolution_i (resolution),
        .dac_code_i   (dac_code),
        .cal_code_i   (cal_code),
        .ack_o        (ack),
        .ready_o      (ready),
        .busy_o       (busy),
        .dac_out_p_o  (dac_out_p),
        .dac_out_n_o  (dac_out_n)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ========================================
    // Stimulus source and reference model
    // ========================================

    // Taps 16,14,13,11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic rand_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);     // One step per bit
            val = {val[14:0], lfsr_state[0]};
        end
    endtask

    function automatic int settle_cycles(input logic [1:0] res);
        case (res)
            2'b00:   return SET_12;
            2'b01:   return SET_14;
            default: return SET_16;
        endcase
    endfunction

    // Code masked to the used bits and left aligned
    function automatic logic [15:0] model_level(input logic [15:0] code, input logic rst,
                                                input logic [1:0] res);
        int          bits;
        logic [15:0] mask;
        if (rst) return 16'h8000;                   // Midscale
        bits = (res == 2'b00) ? 12 : (res == 2'b01) ? 14 : 16;
        mask = 16'hFFFF >> (16 - bits);
        return (code & mask) << (16 - bits);
    endfunction

    function automatic logic [15:0] model_trim(input logic [15:0] lvl, input logic [7:0] cal,
                                               input logic en);
        int gain;
        int ofs;
        int acc;
        if (!en) return lvl;
        gain = int'(cal[7:4]) - 8;
        ofs  = int'(cal[3:0]) - 8;
        acc  = int'(lvl) + ((int'(lvl) * gain) >>> 10) + ofs;
        if (acc < 0) return 16'h0000;
        if (acc > 65535) return 16'hFFFF;
        return 16'(acc);
    endfunction

    // ========================================
    // Checks and handshake tasks
    // ========================================

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("at %0t: %s", $time, what);
            errors++;
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-12s done, %0d errors", name, test_errs);
        test_errs = 0;
    endtask

    // Called at a falling edge with req already high
    task automatic wait_ack_release(input logic [1:0] res, input int hold,
                                    input logic [15:0] exp_p);
        int          waited;
        logic [15:0] exp_n;
        waited = 0;
        exp_n  = ~exp_p;
        do begin
            @(negedge clk);
            waited++;
            if (!ack) check_true(busy, "busy_o low while settling");
        end while (!ack && waited < MAX_HS);
        if (!ack) begin
            check_true(1'b0, "request never acknowledged");
            req = 1'b0;
            return;
        end
        check_eq("ack_o latency", waited - 1, settle_cycles(res) + 1);   // Edges after accept
        check_eq("busy_o", busy, 1'b0);             // Drops on the ack edge
        check_eq("dac_out_p_o", dac_out_p, exp_p);
        check_eq("dac_out_n_o", dac_out_n, exp_n);
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);                         // Slow release
            check_eq("ack_o", ack, 1'b1);
            check_eq("dac_out_p_o", dac_out_p, exp_p);
            check_eq("dac_out_n_o", dac_out_n, exp_n);
        end
        req = 1'b0;
        @(negedge clk);
        check_eq("ack_o", ack, 1'b0);               // Falls on the edge seeing req low
    endtask

    task automatic handshake(input logic [15:0] code, input logic rst, input logic [1:0] res,
                             input int hold, input logic [15:0] exp_p);
        int waited;
        waited = 0;
        while (!ready && waited < MAX_HS) begin
            @(negedge clk);
            waited++;
        end
        check_true(ready, "DUT never became ready for a new request");
        dac_code   = code;
        reset_dac  = rst;
        resolution = res;
        req        = 1'b1;
        wait_ack_release(res, hold, exp_p);
    endtask

    task automatic load_cal(input logic [7:0] cal);
        cal_code  = cal;
        cal_valid = 1'b1;
        @(negedge clk);
        cal_valid = 1'b0;
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial begin
        logic [15:0] code;
        logic [15:0] cal;
        logic [15:0] rbits;
        clk = 1'b0;
        reset_n = 1'b0;
        enable = 1'b1;
        req = 1'b0;
        reset_dac = 1'b0;
        cal_valid = 1'b0;
        cal_enable = 1'b0;
        resolution = 2'b00;
        dac_code = '0;
        cal_code = '0;
        lfsr_state = 16'd28;
        checks = 0;
        errors = 0;
        test_errs = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        @(negedge clk);
        check_eq("ack_o", ack, 1'b0);
        check_eq("busy_o", busy, 1'b0);
        check_eq("ready_o", ready, 1'b1);
        check_eq("dac_out_p_o", dac_out_p, 16'h0000);
        check_eq("dac_out_n_o", dac_out_n, 16'hFFFF);
        end_test("reset");

        // 11 also decodes as 16 bits
        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < N_RAND; i++) begin
                rand_bits(16, code);
                handshake(code, 1'b0, 2'(r), 0, model_level(code, 1'b0, 2'(r)));
            end
        end
        end_test("random");

        for (int r = 0; r < 3; r++) begin
            rand_bits(16, code);
            handshake(code, 1'b1, 2'(r), 0, 16'h8000);
        end
        end_test("midscale");

        cal_enable = 1'b1;
        for (int i = 0; i < N_CAL; i++) begin
            rand_bits(8, cal);
            load_cal(cal[7:0]);
            rand_bits(16, code);
            rand_bits(2, rbits);
            handshake(code, 1'b0, rbits[1:0], 0,
                      model_trim(model_level(code, 1'b0, rbits[1:0]), cal[7:0], 1'b1));
        end
        load_cal(8'h80);                            // Zero gain and offset -8
        handshake(16'h0000, 1'b0, 2'b10, 0, 16'h0000);
        load_cal(8'hFF);                            // Max gain and offset
        handshake(16'hFFFF, 1'b0, 2'b10, 0, 16'hFFFF);
        cal_enable = 1'b0;
        end_test("cal_trim");

        for (int r = 0; r < 3; r++) begin
            rand_bits(16, code);
            handshake(code, 1'b0, 2'(r), 3, model_level(code, 1'b0, 2'(r)));
        end
        end_test("timing");

        // Request held off by enable
        enable = 1'b0;
        rand_bits(16, code);
        dac_code = code;
        reset_dac = 1'b0;
        resolution = 2'b01;
        req = 1'b1;
        repeat (10) begin
            @(negedge clk);
            check_eq("ack_o", ack, 1'b0);
            check_eq("ready_o", ready, 1'b0);
        end
        enable = 1'b1;
        wait_ack_release(2'b01, 0, model_level(code, 1'b0, 2'b01));
        end_test("enable");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with the tests still running", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: src.f
common/dac_array_pkg.sv
common/dac_ctrl_pkg.sv
dac_core/dac_switch_ctrl.sv
dac_core/dac_cal_trim.sv
src/dac_settle_timer.sv
src/sar_dac_top.sv
tests/sar_dac_sva.sv
tests/tb_sar_dac.sv

// File: Makefile
# Verilator build and run for the SAR DAC controller testbench

TOP := tb_sar_dac

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^Simulation completed successfully$$" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir sim.log
